//--- Makefile
TOP = branchPredictorTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f sim.f \
	  --top-module $(TOP) -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; \
	  echo "$$out" | grep -qx 'ALL CHECKS PASSED'

clean:
	rm -rf obj_dir

//--- bpredPkg.sv
////////////////////
// Sizes here are fixed for a 32-bit core without compressed instructions.
// Table indices drop PC bits 1:0, so every fetch address is word aligned.
////////////////////
package bpredPkg;

  ////////////////////
  // Widths and table sizes
  ////////////////////

  // Address width of the core
  localparam int XLEN = 32;

  // Size of one instruction in bytes, used for the fall-through address
  localparam logic [XLEN-1:0] InstrBytes = 4;

  // Return address stack depth and the width of its pointer
  localparam int RasDepth = 8;
  localparam int RasPtrBits = 3;

  // Counter table index comes from PC bits 7:2, giving 64 counters
  localparam int BhtIndexBits = 6;

  // Target buffer index comes from PC bits 6:2 and the tag is everything above
  localparam int BtbIndexBits = 5;
  localparam int BtbTagBits = XLEN - BtbIndexBits - 2;

  ////////////////////
  // Enumerations
  ////////////////////

  // Class of a control instruction as resolved in execute
  typedef enum logic [2:0] {
    classNone,
    classBranch,
    classJump,
    classCall,
    classReturn
  } instrClass;

  // Two-bit saturating counter, the high bit is the taken prediction
  typedef enum logic [1:0] {
    strongNotTaken,
    weakNotTaken,
    weakTaken,
    strongTaken
  } counterState;

endpackage

//--- branchPredictor.sv
////////////////////
// Prediction is combinational from fetchPC; there is no back-pressure.
// A hit on a call or return moves the stack even if fetch is later flushed.
////////////////////
module branchPredictor (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      fetchValid,
  input  logic [bpredPkg::XLEN-1:0] fetchPC,
  input  logic                      updateEn,
  input  logic [bpredPkg::XLEN-1:0] updatePC,
  input  logic [bpredPkg::XLEN-1:0] updateTarget,
  input  bpredPkg::instrClass       updateClass,
  input  logic                      updateTaken,
  input  logic                      rasRestore,
  output logic                      predTaken,
  output logic [bpredPkg::XLEN-1:0] predPC
);

  // Resolution bundle shared by both tables
  updateIf upd ();

  // Lookup results from the tables and the stack
  logic                      btbHit;
  bpredPkg::instrClass       btbClass;
  logic [bpredPkg::XLEN-1:0] btbTarget;
  logic                      dirTaken;
  logic [bpredPkg::XLEN-1:0] rasTop;

  // Steering of the stack and the sequential address
  logic                      entryHit;
  logic                      rasPush;
  logic                      rasPop;
  logic [bpredPkg::XLEN-1:0] fallThrough;

  // The execute stage resolution goes straight onto the bundle
  assign upd.updateEn = updateEn;
  assign upd.updatePC = updatePC;
  assign upd.updateTarget = updateTarget;
  assign upd.updateClass = updateClass;
  assign upd.updateTaken = updateTaken;

  ////////////////////
  // Prediction sources
  ////////////////////

  targetBuffer i_targetBuffer (
    .clk      (clk),
    .reset    (reset),
    .upd      (upd),
    .lookupPC (fetchPC),
    .hit      (btbHit),
    .hitClass (btbClass),
    .hitTarget(btbTarget)
  );

  directionPredictor i_directionPredictor (
    .clk         (clk),
    .reset       (reset),
    .upd         (upd),
    .lookupPC    (fetchPC),
    .predictTaken(dirTaken)
  );

  rasPredictor i_rasPredictor (
    .clk    (clk),
    .reset  (reset),
    .push   (rasPush),
    .pop    (rasPop),
    .restore(rasRestore),
    .pushPC (fallThrough),
    .topPC  (rasTop)
  );

  ////////////////////
  // Next PC selection
  ////////////////////

  assign fallThrough = fetchPC + bpredPkg::InstrBytes;
  assign entryHit = fetchValid && btbHit;

  // Calls save their return point and returns consume it
  assign rasPush = entryHit && (btbClass == bpredPkg::classCall);
  assign rasPop = entryHit && (btbClass == bpredPkg::classReturn);

  always_comb begin
    predTaken = 1'b0;
    predPC = fallThrough;
    if (entryHit) begin
      unique case (btbClass)
        bpredPkg::classJump, bpredPkg::classCall: begin
          predTaken = 1'b1;
          predPC = btbTarget;
        end
        bpredPkg::classReturn: begin
          predTaken = 1'b1;
          predPC = rasTop;
        end
        bpredPkg::classBranch: begin
          // Conditional branches follow their counter
          predTaken = dirTaken;
          predPC = dirTaken ? btbTarget : fallThrough;
        end
        default: begin
          predTaken = 1'b0;
          predPC = fallThrough;
        end
      endcase
    end
  end

endmodule

//--- branchPredictorTb.sv
////////////////////
// One table row per clock cycle; updates in a row are visible from the next row.
////////////////////
module branchPredictorTb;
  timeunit 1ns;
  timeprecision 100ps;

  // Addresses are chosen so that every entry used has its own target buffer index
  localparam logic [31:0] JumpPC = 32'h0000_1000;
  localparam logic [31:0] JumpTarget = 32'h0000_2000;
  localparam logic [31:0] AliasPC = 32'h0000_1080;
  localparam logic [31:0] BranchPC = 32'h0000_4010;
  localparam logic [31:0] BranchTarget = 32'h0000_4800;
  localparam logic [31:0] Call1 = 32'h0000_5104;
  localparam logic [31:0] Call2 = 32'h0000_6108;
  localparam logic [31:0] Call3 = 32'h0000_710c;
  localparam logic [31:0] ReturnPC = 32'h0000_8114;

  logic clk;
  logic reset;
  logic fetchValid;
  logic [bpredPkg::XLEN-1:0] fetchPC;
  logic updateEn;
  logic [bpredPkg::XLEN-1:0] updatePC;
  logic [bpredPkg::XLEN-1:0] updateTarget;
  bpredPkg::instrClass updateClass;
  logic updateTaken;
  logic rasRestore;
  logic predTaken;
  logic [bpredPkg::XLEN-1:0] predPC;

  // One cycle of stimulus and the prediction expected during it
  typedef struct {
    logic updEn;
    bpredPkg::instrClass updClass;
    logic [31:0] updPC;
    logic [31:0] updTarget;
    logic updTaken;
    logic restore;
    logic valid;
    logic [31:0] pc;
    logic expTaken;
    logic [31:0] expPC;
  } stepRow;

  stepRow steps[$];
  int errors = 0;

  branchPredictor i_branchPredictor (
    .clk         (clk),
    .reset       (reset),
    .fetchValid  (fetchValid),
    .fetchPC     (fetchPC),
    .updateEn    (updateEn),
    .updatePC    (updatePC),
    .updateTarget(updateTarget),
    .updateClass (updateClass),
    .updateTaken (updateTaken),
    .rasRestore  (rasRestore),
    .predTaken   (predTaken),
    .predPC      (predPC)
  );

  always #20 clk = ~clk;

  ////////////////////
  // Table building
  ////////////////////

  task automatic appendRow(input logic updEn, input bpredPkg::instrClass cls,
                           input logic [31:0] updPC, input logic [31:0] updTarget,
                           input logic updTaken, input logic restore, input logic valid,
                           input logic [31:0] pc, input logic expTaken,
                           input logic [31:0] expPC);
    stepRow r;
    r = '{updEn, cls, updPC, updTarget, updTaken, restore, valid, pc, expTaken, expPC};
    steps.push_back(r);
  endtask

  // Plain fetch with no update in the same cycle
  task automatic fetchRow(input logic [31:0] pc, input logic expTaken, input logic [31:0] expPC);
    appendRow(1'b0, bpredPkg::classNone, 32'h0, 32'h0, 1'b0, 1'b0, 1'b1, pc, expTaken, expPC);
  endtask

  // Update with fetch idle, so the prediction is the fall-through of address 0
  task automatic updateRow(input bpredPkg::instrClass cls, input logic [31:0] pc,
                           input logic [31:0] target, input logic taken);
    appendRow(1'b1, cls, pc, target, taken, 1'b0, 1'b0, 32'h0, 1'b0, 32'h4);
  endtask

  // Branch update and a fetch of the same branch, which still sees the old counter
  task automatic trainRow(input logic taken, input logic expTaken, input logic [31:0] expPC);
    appendRow(1'b1, bpredPkg::classBranch, BranchPC, BranchTarget, taken, 1'b0, 1'b1,
              BranchPC, expTaken, expPC);
  endtask

  // Nested call addresses step the target buffer index from 8 upward
  function automatic logic [31:0] nestPC(input int k);
    return 32'h0000_9020 + k * 32'h104;
  endfunction

  task automatic buildTable();
    // Empty tables give fall-through everywhere
    fetchRow(32'h0000_0100, 1'b0, 32'h0000_0104);
    fetchRow(32'h0000_2000, 1'b0, 32'h0000_2004);
    fetchRow(JumpPC, 1'b0, JumpPC + 4);
    // Jump allocation, then an alias with a different tag
    updateRow(bpredPkg::classJump, JumpPC, JumpTarget, 1'b1);
    fetchRow(JumpPC, 1'b1, JumpTarget);
    fetchRow(AliasPC, 1'b0, AliasPC + 4);
    // Counter walk: weakNotTaken, weakTaken, weakNotTaken, strongNotTaken and back up
    trainRow(1'b1, 1'b0, BranchPC + 4);
    fetchRow(BranchPC, 1'b1, BranchTarget);
    trainRow(1'b0, 1'b1, BranchTarget);
    trainRow(1'b0, 1'b0, BranchPC + 4);
    fetchRow(BranchPC, 1'b0, BranchPC + 4);
    trainRow(1'b1, 1'b0, BranchPC + 4);
    trainRow(1'b1, 1'b0, BranchPC + 4);
    trainRow(1'b1, 1'b1, BranchTarget);
    // A taken outcome at strongTaken has to hold the counter there
    trainRow(1'b1, 1'b1, BranchTarget);
    trainRow(1'b0, 1'b1, BranchTarget);
    fetchRow(BranchPC, 1'b1, BranchTarget);
    // Three nested calls and their returns
    updateRow(bpredPkg::classCall, Call1, Call1 + 32'h800, 1'b1);
    updateRow(bpredPkg::classCall, Call2, Call2 + 32'h800, 1'b1);
    updateRow(bpredPkg::classCall, Call3, Call3 + 32'h800, 1'b1);
    updateRow(bpredPkg::classReturn, ReturnPC, 32'h0, 1'b1);
    fetchRow(Call1, 1'b1, Call1 + 32'h800);
    fetchRow(Call2, 1'b1, Call2 + 32'h800);
    fetchRow(Call3, 1'b1, Call3 + 32'h800);
    fetchRow(ReturnPC, 1'b1, Call3 + 4);
    fetchRow(ReturnPC, 1'b1, Call2 + 4);
    fetchRow(ReturnPC, 1'b1, Call1 + 4);
    // Restore undoes the last pop
    appendRow(1'b0, bpredPkg::classNone, 32'h0, 32'h0, 1'b0, 1'b1, 1'b0, 32'h0, 1'b0, 32'h4);
    fetchRow(ReturnPC, 1'b1, Call1 + 4);
    // Nine calls overflow the eight entries by one
    for (int k = 0; k < 9; k++) begin
      updateRow(bpredPkg::classCall, nestPC(k), nestPC(k) + 32'h1000, 1'b1);
    end
    for (int k = 0; k < 9; k++) begin
      fetchRow(nestPC(k), 1'b1, nestPC(k) + 32'h1000);
    end
    for (int j = 0; j < 8; j++) begin
      fetchRow(ReturnPC, 1'b1, nestPC(8 - j) + 4);
    end
    // The oldest slot was overwritten by the ninth call
    fetchRow(ReturnPC, 1'b1, nestPC(8) + 4);
  endtask

  ////////////////////
  // Reset and run
  ////////////////////

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #2 reset = 1'b0;
  end

  initial begin
    int waited;
    stepRow r;
    clk = 1'b0;
    fetchValid = 1'b0;
    fetchPC = '0;
    updateEn = 1'b0;
    updatePC = '0;
    updateTarget = '0;
    updateClass = bpredPkg::classNone;
    updateTaken = 1'b0;
    rasRestore = 1'b0;
    buildTable();
    waited = 0;
    while (reset !== 1'b0 && waited < 10) begin
      @(posedge clk);
      waited++;
    end
    if (reset !== 1'b0) begin
      $display("Reset was still high after 10 cycles, the run is stopped");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      for (int i = 0; i < steps.size(); i++) begin
        r = steps[i];
        #2;
        updateEn = r.updEn;
        updateClass = r.updClass;
        updatePC = r.updPC;
        updateTarget = r.updTarget;
        updateTaken = r.updTaken;
        rasRestore = r.restore;
        fetchValid = r.valid;
        fetchPC = r.pc;
        // Sample 5 ns before the next edge, long after the inputs settled
        #33;
        assert (predTaken === r.expTaken) else begin
          errors++;
          $display("CHECK FAILED at %0t: row %0d predTaken expected %0b, got %0b",
                   $time, i, r.expTaken, predTaken);
        end
        assert (predPC === r.expPC) else begin
          errors++;
          $display("CHECK FAILED at %0t: row %0d predPC expected %h, got %h",
                   $time, i, r.expPC, predPC);
        end
        @(posedge clk);
      end
      $display("Rows applied: %0d, errors: %0d", steps.size(), errors);
      if (errors == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

//--- directionPredictor.sv
////////////////////
// Counters are trained by branches only and are shared by aliasing PCs.
////////////////////
module directionPredictor (
  input  logic                      clk,
  input  logic                      reset,
  updateIf.tables                   upd,
  input  logic [bpredPkg::XLEN-1:0] lookupPC,
  output logic                      predictTaken
);

  // One saturating counter per index
  bpredPkg::counterState counters [2**bpredPkg::BhtIndexBits];

  // Index bits for the fetch read and for the training write
  logic [bpredPkg::BhtIndexBits-1:0] lookupIdx;
  logic [bpredPkg::BhtIndexBits-1:0] updateIdx;

  // Current and next state of the counter being trained
  bpredPkg::counterState trainOld;
  bpredPkg::counterState trainNew;

  // Raw bits of the counter read at fetch
  logic [1:0] lookupBits;

  assign lookupIdx = lookupPC[bpredPkg::BhtIndexBits+1:2];
  assign updateIdx = upd.updatePC[bpredPkg::BhtIndexBits+1:2];

  ////////////////////
  // Training
  ////////////////////

  assign trainOld = counters[updateIdx];

  // Step one state toward the outcome and hold at either end
  always_comb begin
    unique case (trainOld)
      bpredPkg::strongNotTaken:
        trainNew = upd.updateTaken ? bpredPkg::weakNotTaken : bpredPkg::strongNotTaken;
      bpredPkg::weakNotTaken:
        trainNew = upd.updateTaken ? bpredPkg::weakTaken : bpredPkg::strongNotTaken;
      bpredPkg::weakTaken:
        trainNew = upd.updateTaken ? bpredPkg::strongTaken : bpredPkg::weakNotTaken;
      default:
        trainNew = upd.updateTaken ? bpredPkg::strongTaken : bpredPkg::weakTaken;
    endcase
  end

  // Counters wake up weakly not taken so one taken outcome flips them
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2**bpredPkg::BhtIndexBits; i++) begin
        counters[i] <= bpredPkg::weakNotTaken;
      end
    end else if (upd.updateEn && upd.updateClass == bpredPkg::classBranch) begin
      counters[updateIdx] <= trainNew;
    end
  end

  ////////////////////
  // Fetch read
  ////////////////////

  // The high bit of the counter is the direction
  assign lookupBits = counters[lookupIdx];
  assign predictTaken = lookupBits[1];

endmodule

//--- rasPredictor.sv
////////////////////
// No checkpoints, so a mispredicted call leaves the stack corrupted.
// Overflow wraps and overwrites the oldest entry without notice.
////////////////////
module rasPredictor (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      push,
  input  logic                      pop,
  input  logic                      restore,
  input  logic [bpredPkg::XLEN-1:0] pushPC,
  output logic [bpredPkg::XLEN-1:0] topPC
);

  // Pointer to the current top entry and its two neighbours
  logic [bpredPkg::RasPtrBits-1:0] ptr;
  logic [bpredPkg::RasPtrBits-1:0] ptrUp;
  logic [bpredPkg::RasPtrBits-1:0] ptrDown;

  // Circular storage of return addresses
  logic [bpredPkg::XLEN-1:0] stack [bpredPkg::RasDepth];

  // Pointer arithmetic wraps naturally at the stack depth
  assign ptrUp = ptr + 1'b1;
  assign ptrDown = ptr - 1'b1;

  ////////////////////
  // Pointer update
  ////////////////////

  // A restore undoes one pop, so it steps up just like a push
  // but leaves the entry untouched
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ptr <= '0;
    end else if (push || restore) begin
      ptr <= ptrUp;
    end else if (pop) begin
      ptr <= ptrDown;
    end
  end

  ////////////////////
  // Entry storage
  ////////////////////

  // Entries start at zero so a return before any call predicts address 0
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < bpredPkg::RasDepth; i++) begin
        stack[i] <= '0;
      end
    end else if (push) begin
      stack[ptrUp] <= pushPC;
    end
  end

  // The top is read combinationally so a return sees it in its own cycle
  assign topPC = stack[ptr];

  // The flush that raises restore never lines up with a popping or pushing fetch
  assert property (@(posedge clk) disable iff (reset) !(pop && restore));
  assert property (@(posedge clk) disable iff (reset) !(push && restore));

endmodule

//--- sim.f
bpredPkg.sv
updateIf.sv
rasPredictor.sv
directionPredictor.sv
targetBuffer.sv
branchPredictor.sv
branchPredictorTb.sv

//--- targetBuffer.sv
////////////////////
// Direct mapped, so two control instructions with the same index evict each other.
// Entries are written on every resolution, taken or not.
////////////////////
module targetBuffer (
  input  logic                      clk,
  input  logic                      reset,
  updateIf.tables                   upd,
  input  logic [bpredPkg::XLEN-1:0] lookupPC,
  output logic                      hit,
  output bpredPkg::instrClass       hitClass,
  output logic [bpredPkg::XLEN-1:0] hitTarget
);

  localparam int Entries = 2**bpredPkg::BtbIndexBits;

  // Valid bits are control state, the rest of an entry is payload
  logic                              valid [Entries];
  logic [bpredPkg::BtbTagBits-1:0]   tags [Entries];
  bpredPkg::instrClass               classes [Entries];
  logic [bpredPkg::XLEN-1:0]         targets [Entries];

  // Index and tag fields of the fetch address
  logic [bpredPkg::BtbIndexBits-1:0] lookupIdx;
  logic [bpredPkg::BtbTagBits-1:0]   lookupTag;

  // Index and tag fields of the resolved address
  logic [bpredPkg::BtbIndexBits-1:0] updateIdx;
  logic [bpredPkg::BtbTagBits-1:0]   updateTag;

  // Only real control instructions are allocated
  logic                              writeEn;

  assign lookupIdx = lookupPC[bpredPkg::BtbIndexBits+1:2];
  assign lookupTag = lookupPC[bpredPkg::XLEN-1:bpredPkg::BtbIndexBits+2];
  assign updateIdx = upd.updatePC[bpredPkg::BtbIndexBits+1:2];
  assign updateTag = upd.updatePC[bpredPkg::XLEN-1:bpredPkg::BtbIndexBits+2];

  assign writeEn = upd.updateEn && upd.updateClass != bpredPkg::classNone;

  ////////////////////
  // Table write
  ////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < Entries; i++) begin
        valid[i] <= 1'b0;
      end
    end else if (writeEn) begin
      valid[updateIdx] <= 1'b1;
    end
  end

  // Tag, class and target of the resolved instruction
  always_ff @(posedge clk) begin
    if (writeEn) begin
      tags[updateIdx] <= updateTag;
      classes[updateIdx] <= upd.updateClass;
      targets[updateIdx] <= upd.updateTarget;
    end
  end

  ////////////////////
  // Fetch lookup
  ////////////////////

  // A hit needs a live entry whose tag matches the upper fetch bits
  assign hit = valid[lookupIdx] && (tags[lookupIdx] == lookupTag);
  assign hitClass = classes[lookupIdx];
  assign hitTarget = targets[lookupIdx];

  // Execute never reports a taken outcome for a non-control instruction
  assert property (@(posedge clk) disable iff (reset)
    !(upd.updateEn && upd.updateClass == bpredPkg::classNone && upd.updateTaken));

endmodule

//--- updateIf.sv
////////////////////
// One resolved control instruction per cycle, with no handshake.
////////////////////
interface updateIf;

  // Strobe that writes the tables at the next rising edge
  logic updateEn;

  // Address of the resolved instruction and its computed target
  logic [bpredPkg::XLEN-1:0] updatePC;
  logic [bpredPkg::XLEN-1:0] updateTarget;

  // Class of the resolved instruction and its actual direction
  bpredPkg::instrClass updateClass;
  logic updateTaken;

  // The execute stage drives a resolution
  modport source (
    output updateEn,
    output updatePC,
    output updateTarget,
    output updateClass,
    output updateTaken
  );

  // Prediction tables only observe the resolution
  modport tables (
    input updateEn,
    input updatePC,
    input updateTarget,
    input updateClass,
    input updateTaken
  );

endinterface
